//--- src/dma_pkg.sv
// DMA shared definitions: field widths, table geometry, register offsets, engine states
package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and link geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W         = 32;   // Bus and link word
  localparam int ADDR_W         = 16;   // Bus byte address
  localparam int MEM_WINDOW_BIT = 12;   // Set: access hits local memory

  // Request table
  localparam int TABLE_ENTRIES  = 4;
  localparam int TABLE_PTR_W    = 2;

  // Request fields
  localparam int LADDR_W        = 8;    // Local word address
  localparam int MEM_WORDS      = 256;
  localparam int SIZE_W         = 8;    // Payload words, zero = header only
  localparam int RTILE_W        = 8;    // Header bits 31:24
  localparam int RADDR_W        = 24;   // Header bits 23:0

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Word offset inside an entry, address bits 4:2
  typedef enum logic [2:0] {
    OFF_LADDR = 3'd0,
    OFF_SIZE  = 3'd1,
    OFF_RTILE = 3'd2,
    OFF_RADDR = 3'd3,
    OFF_CTRL  = 3'd5    // Byte offset 0x14
  } reg_off_e;

  // Transfer engine sequence
  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_HEADER,
    ENG_READ,
    ENG_SEND,
    ENG_ACK_LOW
  } eng_state_e;

endpackage

//--- src/dma_bus_decode.sv
// DMA bus slave: splits accesses into table field writes, start strobes, status and memory
module dma_bus_decode (
  input  logic                          clk,
  input  logic                          rst_i,
  // Processor bus, single-cycle enable access
  input  logic                          bus_en_i,
  input  logic                          bus_we_i,
  input  logic [dma_pkg::ADDR_W-1:0]    bus_addr_i,
  input  logic [dma_pkg::DATA_W-1:0]    bus_wdata_i,
  output logic [dma_pkg::DATA_W-1:0]    bus_rdata_o,
  // Table field write, offset also selects the read word
  output logic                          fld_we_o,
  output logic [dma_pkg::TABLE_PTR_W-1:0] fld_entry_o,
  output dma_pkg::reg_off_e             fld_sel_o,
  output logic [dma_pkg::DATA_W-1:0]    fld_data_o,
  // Start strobe
  output logic                          start_en_o,
  output logic [dma_pkg::TABLE_PTR_W-1:0] start_entry_o,
  // Status and field readback
  output logic [dma_pkg::TABLE_PTR_W-1:0] stat_entry_o,
  input  logic [dma_pkg::DATA_W-1:0]    stat_word_i,
  // Local memory port
  output logic                          mem_en_o,
  output logic                          mem_we_o,
  output logic [dma_pkg::LADDR_W-1:0]   mem_addr_o,
  output logic [dma_pkg::DATA_W-1:0]    mem_wdata_o,
  input  logic [dma_pkg::DATA_W-1:0]    mem_rdata_i
);
  import dma_pkg::*;

  logic                   mem_win;
  logic                   tbl_acc;
  logic [TABLE_PTR_W-1:0] entry;
  reg_off_e               off;
  logic                   mem_sel_q;    // Last read went to memory
  logic [DATA_W-1:0]      tbl_rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address split
  ////////////////////////////////////////////////////////////////////////////

  assign mem_win = bus_addr_i[MEM_WINDOW_BIT];
  assign tbl_acc = bus_en_i & ~mem_win;
  // 32-byte stride per entry
  assign entry   = bus_addr_i[TABLE_PTR_W+4:5];
  assign off     = reg_off_e'(bus_addr_i[4:2]);

  // Field writes, CTRL goes to the start strobe instead
  assign fld_we_o      = tbl_acc & bus_we_i & (off != OFF_CTRL);
  assign fld_entry_o   = entry;
  assign fld_sel_o     = off;
  assign fld_data_o    = bus_wdata_i;

  // Only bit 0 of a CTRL write launches
  assign start_en_o    = tbl_acc & bus_we_i & (off == OFF_CTRL) & bus_wdata_i[0];
  assign start_entry_o = entry;
  assign stat_entry_o  = entry;

  // Memory window, word index from bits 9:2
  assign mem_en_o    = bus_en_i & mem_win;
  assign mem_we_o    = bus_we_i;
  assign mem_addr_o  = bus_addr_i[LADDR_W+1:2];
  assign mem_wdata_o = bus_wdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Table word captured at the access, memory word arrives one cycle later
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mem_sel_q   <= 1'b0;
      tbl_rdata_q <= '0;
    end else begin
      mem_sel_q <= bus_en_i & ~bus_we_i & mem_win;
      if (tbl_acc & ~bus_we_i) begin
        tbl_rdata_q <= stat_word_i;
      end
    end
  end

  assign bus_rdata_o = mem_sel_q ? mem_rdata_i : tbl_rdata_q;

  // Enable must be a clean level once out of reset
  a_en_known: assert property (@(posedge clk) disable iff (rst_i) !$isunknown(bus_en_i));

endmodule

//--- src/dma_request_table.sv
// DMA request table: per-entry fields, pending/done tracking and lowest-index job handoff
module dma_request_table (
  input  logic                            clk,
  input  logic                            rst_i,
  // Field writes from the bus decoder
  input  logic                            fld_we_i,
  input  logic [dma_pkg::TABLE_PTR_W-1:0] fld_entry_i,
  input  dma_pkg::reg_off_e               fld_sel_i,
  input  logic [dma_pkg::DATA_W-1:0]      fld_data_i,
  input  logic                            start_en_i,
  input  logic [dma_pkg::TABLE_PTR_W-1:0] start_entry_i,
  // Readback
  input  logic [dma_pkg::TABLE_PTR_W-1:0] stat_entry_i,
  output logic [dma_pkg::DATA_W-1:0]      stat_word_o,
  // Job handshake toward the engine
  output logic                            job_req_o,
  output logic [dma_pkg::TABLE_PTR_W-1:0] job_entry_o,
  output logic [dma_pkg::LADDR_W-1:0]     job_laddr_o,
  output logic [dma_pkg::SIZE_W-1:0]      job_size_o,
  output logic [dma_pkg::RTILE_W-1:0]     job_rtile_o,
  output logic [dma_pkg::RADDR_W-1:0]     job_raddr_o,
  input  logic                            job_ack_i
);
  import dma_pkg::*;

  // Field storage
  logic [LADDR_W-1:0]       laddr_q [TABLE_ENTRIES];
  logic [SIZE_W-1:0]        size_q  [TABLE_ENTRIES];
  logic [RTILE_W-1:0]       rtile_q [TABLE_ENTRIES];
  logic [RADDR_W-1:0]       raddr_q [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] pend_q;
  logic [TABLE_ENTRIES-1:0] done_q;
  // Priority pick
  logic                     pick_vld;
  logic [TABLE_PTR_W-1:0]   pick_idx;

  // Payload registers, low bits of the write data
  always_ff @(posedge clk) begin
    if (fld_we_i) begin
      case (fld_sel_i)
        OFF_LADDR: laddr_q[fld_entry_i] <= fld_data_i[LADDR_W-1:0];
        OFF_SIZE:  size_q[fld_entry_i]  <= fld_data_i[SIZE_W-1:0];
        OFF_RTILE: rtile_q[fld_entry_i] <= fld_data_i[RTILE_W-1:0];
        OFF_RADDR: raddr_q[fld_entry_i] <= fld_data_i[RADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // Readback, zero-extended
  always_comb begin
    stat_word_o = '0;
    case (fld_sel_i)
      OFF_LADDR: stat_word_o[LADDR_W-1:0] = laddr_q[stat_entry_i];
      OFF_SIZE:  stat_word_o[SIZE_W-1:0]  = size_q[stat_entry_i];
      OFF_RTILE: stat_word_o[RTILE_W-1:0] = rtile_q[stat_entry_i];
      OFF_RADDR: stat_word_o[RADDR_W-1:0] = raddr_q[stat_entry_i];
      OFF_CTRL:  stat_word_o[1:0]         = {pend_q[stat_entry_i], done_q[stat_entry_i]};
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Job selection and handshake
  ////////////////////////////////////////////////////////////////////////////

  // Lowest pending index wins, scanned downward so the last hit is lowest
  always_comb begin
    pick_vld = 1'b0;
    pick_idx = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        pick_vld = 1'b1;
        pick_idx = TABLE_PTR_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pend_q      <= '0;
      done_q      <= '0;
      job_req_o   <= 1'b0;
      job_entry_o <= '0;
    end else begin
      // Engine finished: retire the entry and release the request
      if (job_req_o && job_ack_i) begin
        job_req_o             <= 1'b0;
        pend_q[job_entry_o]   <= 1'b0;
        done_q[job_entry_o]   <= 1'b1;
      end else if (!job_req_o && !job_ack_i && pick_vld) begin
        // Handshake idle, hand out the next entry
        job_req_o   <= 1'b1;
        job_entry_o <= pick_idx;
      end
      // Start last so a fresh start survives a same-cycle retire
      if (start_en_i) begin
        pend_q[start_entry_i] <= 1'b1;
        done_q[start_entry_i] <= 1'b0;
      end
    end
  end

  // Fields of the latched entry, stable while the request is up
  assign job_laddr_o = laddr_q[job_entry_o];
  assign job_size_o  = size_q[job_entry_o];
  assign job_rtile_o = rtile_q[job_entry_o];
  assign job_raddr_o = raddr_q[job_entry_o];

  // Handed-out entry stays pending for the whole handshake
  a_job_pending: assert property (@(posedge clk) disable iff (rst_i)
    job_req_o |-> pend_q[job_entry_o]);

endmodule

//--- src/dma_local_mem.sv
// DMA scratch RAM: bus read/write port plus an engine read port, both registered
module dma_local_mem (
  input  logic                        clk,
  // Bus port
  input  logic                        bus_en_i,
  input  logic                        bus_we_i,
  input  logic [dma_pkg::LADDR_W-1:0] bus_addr_i,
  input  logic [dma_pkg::DATA_W-1:0]  bus_wdata_i,
  output logic [dma_pkg::DATA_W-1:0]  bus_rdata_o,
  // Engine port, read only
  input  logic                        eng_rd_en_i,
  input  logic [dma_pkg::LADDR_W-1:0] eng_rd_addr_i,
  output logic [dma_pkg::DATA_W-1:0]  eng_rd_data_o
);
  import dma_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  ////////////////////////////////////////////////////////////////////////////
  // Bus port
  ////////////////////////////////////////////////////////////////////////////

  // Write or read per access, read data one cycle later
  always_ff @(posedge clk) begin
    if (bus_en_i) begin
      if (bus_we_i) begin
        mem_q[bus_addr_i] <= bus_wdata_i;
      end else begin
        bus_rdata_o <= mem_q[bus_addr_i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Engine port
  ////////////////////////////////////////////////////////////////////////////

  // Fixed one-cycle latency, holds until the next read
  always_ff @(posedge clk) begin
    if (eng_rd_en_i) begin
      eng_rd_data_o <= mem_q[eng_rd_addr_i];
    end
  end

endmodule

//--- src/dma_transfer_engine.sv
// DMA transfer engine: sends header then payload words over a four-phase req/ack link
module dma_transfer_engine (
  input  logic                        clk,
  input  logic                        rst_i,
  // Job handshake from the request table
  input  logic                        job_req_i,
  input  logic [dma_pkg::LADDR_W-1:0] job_laddr_i,
  input  logic [dma_pkg::SIZE_W-1:0]  job_size_i,
  input  logic [dma_pkg::RTILE_W-1:0] job_rtile_i,
  input  logic [dma_pkg::RADDR_W-1:0] job_raddr_i,
  output logic                        job_ack_o,
  // Local memory read, data one cycle after rd_en_o
  output logic                        rd_en_o,
  output logic [dma_pkg::LADDR_W-1:0] rd_addr_o,
  input  logic [dma_pkg::DATA_W-1:0]  rd_data_i,
  // Outbound link
  output logic                        link_req_o,
  output logic [dma_pkg::DATA_W-1:0]  link_data_o,
  input  logic                        link_ack_i
);
  import dma_pkg::*;

  eng_state_e         state_q;
  logic [SIZE_W-1:0]  cnt_q;     // Payload words still to send
  logic [LADDR_W-1:0] addr_q;    // Next local word, wraps mod 256
  logic               load_hdr;
  logic               load_word;

  // New job only once the previous ack phase is over
  assign load_hdr  = (state_q == ENG_IDLE) & job_req_i & ~job_ack_o;
  // First SEND cycle, memory data is valid now
  assign load_word = (state_q == ENG_SEND) & ~link_req_o;

  assign rd_en_o   = (state_q == ENG_READ);
  assign rd_addr_o = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= ENG_IDLE;
      cnt_q      <= '0;
      addr_q     <= '0;
      job_ack_o  <= 1'b0;
      link_req_o <= 1'b0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          // Drop ack once the table released its request
          if (job_ack_o && !job_req_i) begin
            job_ack_o <= 1'b0;
          end else if (load_hdr) begin
            cnt_q      <= job_size_i;
            addr_q     <= job_laddr_i;
            link_req_o <= 1'b1;
            state_q    <= ENG_HEADER;
          end
        end
        ENG_HEADER, ENG_SEND: begin
          if (load_word) begin
            link_req_o <= 1'b1;
            cnt_q      <= cnt_q - 1'b1;
            addr_q     <= addr_q + 1'b1;
          end else if (link_ack_i) begin
            // Sink took the word
            link_req_o <= 1'b0;
            state_q    <= ENG_ACK_LOW;
          end
        end
        ENG_READ: state_q <= ENG_SEND;
        ENG_ACK_LOW: begin
          // Wait for ack low before the next word, or finish the job
          if (!link_ack_i) begin
            if (cnt_q == '0) begin
              job_ack_o <= 1'b1;
              state_q   <= ENG_IDLE;
            end else begin
              state_q <= ENG_READ;
            end
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  // Link word register, header is rtile over raddr
  always_ff @(posedge clk) begin
    if (load_hdr) begin
      link_data_o <= {job_rtile_i, job_raddr_i};
    end else if (load_word) begin
      link_data_o <= rd_data_i;
    end
  end

  // Word held until the sink acknowledges
  a_link_stable: assert property (@(posedge clk) disable iff (rst_i)
    (link_req_o && !link_ack_i) |=> $stable(link_data_o));

endmodule

//--- src/dma_top.sv
// DMA tile subsystem top: bus decoder, request table, scratch memory and transfer engine
module dma_top (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       bus_en_i,
  input  logic                       bus_we_i,
  input  logic [dma_pkg::ADDR_W-1:0] bus_addr_i,
  input  logic [dma_pkg::DATA_W-1:0] bus_wdata_i,
  output logic [dma_pkg::DATA_W-1:0] bus_rdata_o,
  output logic                       link_req_o,
  output logic [dma_pkg::DATA_W-1:0] link_data_o,
  input  logic                       link_ack_i
);
  import dma_pkg::*;

  // Decoder to table
  logic                   fld_we;
  logic [TABLE_PTR_W-1:0] fld_entry;
  reg_off_e               fld_sel;
  logic [DATA_W-1:0]      fld_data;
  logic                   start_en;
  logic [TABLE_PTR_W-1:0] start_entry;
  logic [TABLE_PTR_W-1:0] stat_entry;
  logic [DATA_W-1:0]      stat_word;
  // Decoder to memory
  logic                   bus_mem_en;
  logic                   bus_mem_we;
  logic [LADDR_W-1:0]     bus_mem_addr;
  logic [DATA_W-1:0]      bus_mem_wdata;
  logic [DATA_W-1:0]      bus_mem_rdata;
  // Table to engine
  logic                   job_req;
  logic [LADDR_W-1:0]     job_laddr;
  logic [SIZE_W-1:0]      job_size;
  logic [RTILE_W-1:0]     job_rtile;
  logic [RADDR_W-1:0]     job_raddr;
  logic                   job_ack;
  // Engine to memory
  logic                   eng_rd_en;
  logic [LADDR_W-1:0]     eng_rd_addr;
  logic [DATA_W-1:0]      eng_rd_data;

  dma_bus_decode u_decode (
    .clk           (clk),
    .rst_i         (rst_i),
    .bus_en_i      (bus_en_i),
    .bus_we_i      (bus_we_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_rdata_o   (bus_rdata_o),
    .fld_we_o      (fld_we),
    .fld_entry_o   (fld_entry),
    .fld_sel_o     (fld_sel),
    .fld_data_o    (fld_data),
    .start_en_o    (start_en),
    .start_entry_o (start_entry),
    .stat_entry_o  (stat_entry),
    .stat_word_i   (stat_word),
    .mem_en_o      (bus_mem_en),
    .mem_we_o      (bus_mem_we),
    .mem_addr_o    (bus_mem_addr),
    .mem_wdata_o   (bus_mem_wdata),
    .mem_rdata_i   (bus_mem_rdata)
  );

  // Entry index of the job stays internal to the table
  dma_request_table u_table (
    .clk           (clk),
    .rst_i         (rst_i),
    .fld_we_i      (fld_we),
    .fld_entry_i   (fld_entry),
    .fld_sel_i     (fld_sel),
    .fld_data_i    (fld_data),
    .start_en_i    (start_en),
    .start_entry_i (start_entry),
    .stat_entry_i  (stat_entry),
    .stat_word_o   (stat_word),
    .job_req_o     (job_req),
    .job_entry_o   (),
    .job_laddr_o   (job_laddr),
    .job_size_o    (job_size),
    .job_rtile_o   (job_rtile),
    .job_raddr_o   (job_raddr),
    .job_ack_i     (job_ack)
  );

  dma_local_mem u_mem (
    .clk           (clk),
    .bus_en_i      (bus_mem_en),
    .bus_we_i      (bus_mem_we),
    .bus_addr_i    (bus_mem_addr),
    .bus_wdata_i   (bus_mem_wdata),
    .bus_rdata_o   (bus_mem_rdata),
    .eng_rd_en_i   (eng_rd_en),
    .eng_rd_addr_i (eng_rd_addr),
    .eng_rd_data_o (eng_rd_data)
  );

  dma_transfer_engine u_engine (
    .clk         (clk),
    .rst_i       (rst_i),
    .job_req_i   (job_req),
    .job_laddr_i (job_laddr),
    .job_size_i  (job_size),
    .job_rtile_i (job_rtile),
    .job_raddr_i (job_raddr),
    .job_ack_o   (job_ack),
    .rd_en_o     (eng_rd_en),
    .rd_addr_o   (eng_rd_addr),
    .rd_data_i   (eng_rd_data),
    .link_req_o  (link_req_o),
    .link_data_o (link_data_o),
    .link_ack_i  (link_ack_i)
  );

endmodule

//--- tb/dma_tb.sv
// DMA subsystem testbench: replays the tests file, models the link sink, checks bus and link
module dma_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import dma_pkg::*;

  localparam int          POLL_LIMIT = 200;   // Control word reads per done poll
  localparam int          HOLD_LIMIT = 100;   // Cycles the sink holds ack for one word
  localparam logic [15:0] LFSR_SEED  = 16'd27007;

  typedef enum logic [1:0] {
    SINK_IDLE,
    SINK_WAIT,
    SINK_HOLD
  } sink_state_e;

  // DUT inputs
  logic              clk         = 1'b0;
  logic              rst_i       = 1'b1;
  logic              bus_en_i    = 1'b0;
  logic              bus_we_i    = 1'b0;
  logic [ADDR_W-1:0] bus_addr_i  = '0;
  logic [DATA_W-1:0] bus_wdata_i = '0;
  logic              link_ack_i  = 1'b0;
  // DUT outputs
  logic [DATA_W-1:0] bus_rdata_o;
  logic              link_req_o;
  logic [DATA_W-1:0] link_data_o;

  // Expected link words, filled by the replay, consumed by the sink through rx_idx
  logic [DATA_W-1:0] exp_q [$];
  int                rx_idx     = 0;
  int                link_words = 0;
  int                check_errs = 0;
  int                link_errs  = 0;
  int                timeouts   = 0;
  logic              abort_run  = 1'b0;
  logic              sink_stuck = 1'b0;

  // Sink state
  sink_state_e       sink_st  = SINK_IDLE;
  logic [2:0]        wait_cnt = '0;
  int                hold_cnt = 0;
  logic [15:0]       lfsr_q   = LFSR_SEED;

  // Period 20 ns
  initial begin
    forever #10 clk = ~clk;
  end

  dma_top dut_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_en_i    (bus_en_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rdata_o (bus_rdata_o),
    .link_req_o  (link_req_o),
    .link_data_o (link_data_o),
    .link_ack_i  (link_ack_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = s >> 1;
    if (s[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  // One-cycle enable access
  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge clk);
    bus_en_i    <= 1'b1;
    bus_we_i    <= 1'b1;
    bus_addr_i  <= addr;
    bus_wdata_i <= data;
    @(posedge clk);
    bus_en_i    <= 1'b0;
    bus_we_i    <= 1'b0;
  endtask

  // Data registered at the access edge, sampled half a cycle later
  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(posedge clk);
    bus_en_i   <= 1'b1;
    bus_we_i   <= 1'b0;
    bus_addr_i <= addr;
    @(posedge clk);
    bus_en_i   <= 1'b0;
    @(negedge clk);
    data = bus_rdata_o;
  endtask

  task automatic check_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] rd;
    bus_read(addr, rd);
    if (rd !== exp) begin
      $display("Fail bus_rdata_o at %h: got %h expected %h", addr, rd, exp);
      check_errs++;
    end
  endtask

  // Control word: bit 0 done, bit 1 pending
  task automatic poll_done(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] rd;
    int                tries;
    rd    = '0;
    tries = 0;
    while (!rd[0] && tries < POLL_LIMIT) begin
      bus_read(addr, rd);
      tries++;
    end
    if (!rd[0]) begin
      $display("Timeout: control word at %h never reported done", addr);
      timeouts++;
      abort_run = 1'b1;
    end else if (rd !== 32'h1) begin
      $display("Fail bus_rdata_o at %h: got %h expected %h", addr, rd, 32'h1);
      check_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Link sink with random ack delay
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : link_sink
    logic [2:0] delay;
    if (rst_i) begin
      link_ack_i <= 1'b0;
      sink_st    <= SINK_IDLE;
    end else begin
      case (sink_st)
        SINK_IDLE: begin
          if (link_req_o) begin
            link_words++;
            if (rx_idx >= exp_q.size()) begin
              $display("Link word %h arrived with no expected word left", link_data_o);
              link_errs++;
            end else begin
              if (link_data_o !== exp_q[rx_idx]) begin
                $display("Fail link_data_o: got %h expected %h", link_data_o, exp_q[rx_idx]);
                link_errs++;
              end
              rx_idx++;
            end
            // Three LFSR bits per delay, 0 to 7 cycles
            delay = '0;
            for (int i = 0; i < 3; i++) begin
              delay  = {delay[1:0], lfsr_q[0]};
              lfsr_q = lfsr_step(lfsr_q);
            end
            if (delay == 3'd0) begin
              link_ack_i <= 1'b1;
              hold_cnt   <= 0;
              sink_st    <= SINK_HOLD;
            end else begin
              wait_cnt <= delay;
              sink_st  <= SINK_WAIT;
            end
          end
        end
        SINK_WAIT: begin
          if (wait_cnt == 3'd1) begin
            link_ack_i <= 1'b1;
            hold_cnt   <= 0;
            sink_st    <= SINK_HOLD;
          end else begin
            wait_cnt <= wait_cnt - 3'd1;
          end
        end
        SINK_HOLD: begin
          // Release ack once the engine drops its request
          if (!link_req_o) begin
            link_ack_i <= 1'b0;
            sink_st    <= SINK_IDLE;
          end else begin
            if (hold_cnt == HOLD_LIMIT) begin
              $display("Timeout: link request stayed high after ack");
              link_errs++;
              sink_stuck <= 1'b1;
            end
            hold_cnt <= hold_cnt + 1;
          end
        end
        default: sink_st <= SINK_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Replay of the tests file
  ////////////////////////////////////////////////////////////////////////////

  initial begin : replay
    int                fd;
    int                n;
    string             line;
    byte               kind;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    // Idle outputs after reset
    if (link_req_o !== 1'b0) begin
      $display("Fail link_req_o after reset: got %h expected %h", link_req_o, 1'b0);
      check_errs++;
    end
    if (bus_rdata_o !== '0) begin
      $display("Fail bus_rdata_o after reset: got %h expected %h", bus_rdata_o, 32'h0);
      check_errs++;
    end
    fd = $fopen("tb/dma_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/dma_tests.txt");
      check_errs++;
    end
    while (fd != 0 && !abort_run && !sink_stuck && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        kind = line[0];
        addr = '0;
        data = '0;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
        case (kind)
          "W": bus_write(addr, data);
          "R": check_read(addr, data);
          "E": exp_q.push_back(data);
          "D": poll_done(addr);
          default: begin
            $display("Unknown line kind in tests file: %s", line);
            check_errs++;
          end
        endcase
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    // Every expected word consumed, none left over
    if (!abort_run && !sink_stuck && rx_idx != exp_q.size()) begin
      $display("%0d expected link words never arrived", exp_q.size() - rx_idx);
      check_errs++;
    end
    $display("Summary: %0d link words, %0d check errors, %0d link errors, %0d timeouts",
             link_words, check_errs, link_errs, timeouts);
    if (check_errs + link_errs + timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
src/dma_pkg.sv
src/dma_bus_decode.sv
src/dma_request_table.sv
src/dma_local_mem.sv
src/dma_transfer_engine.sv
src/dma_top.sv
tb/dma_tb.sv

//--- Makefile
# Verilator build and run for the DMA subsystem testbench

VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
FAIL_MSG  ?= CHECKS FAILED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/dma_tests.txt
# kind addr data, all hex. W write, R read and expect data, E expected link word (addr unused)
# D polls the control word at addr until done, then expects done=1 pending=0
W 1040 a5a50010
W 1044 a5a50011
W 1048 a5a50012
W 13f8 cafe00fe
W 13fc cafe00ff
W 1000 cafe0000
R 1044 a5a50011
R 13fc cafe00ff
R 1000 cafe0000
W 0000 ffffff10
W 0004 00000003
W 0008 12345607
W 000c ab123456
R 0000 00000010
R 0004 00000003
R 0008 00000007
R 000c 00123456
R 0014 00000000
W 0020 000000fe
W 0024 00000003
W 0028 00000009
W 002c 00000abc
W 0040 00000000
W 0044 00000000
W 0048 0000000a
W 004c ff00beef
R 004c 0000beef
E 0000 0a00beef
E 0000 07123456
E 0000 a5a50010
E 0000 a5a50011
E 0000 a5a50012
E 0000 09000abc
E 0000 cafe00fe
E 0000 cafe00ff
E 0000 cafe0000
W 0054 00000001
W 0034 00000001
W 0014 00000001
D 0054 00000000
D 0014 00000000
D 0034 00000000
R 0054 00000001
